// ==== rtl/isaPkg.sv ====
// Word and address widths, instruction memory geometry and reset vector
`default_nettype none

package isaPkg;

    ////////////////////
    // Word geometry
    ////////////////////

    // Data, address and instruction width of the processor
    localparam int WORD_W = 32;

    // Width of the absolute jump field carried in a J-type instruction
    localparam int IMM_W = 26;

    // Bytes in one word, the step of the sequential address
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // Address bits below the word index
    localparam int WORD_OFFSET_W = $clog2(BYTES_PER_WORD);

    typedef logic [WORD_W-1:0] wordT;

    ////////////////////
    // Instruction memory
    ////////////////////

    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    // Hex image loaded into the instruction store at elaboration
    localparam string IMEM_FILE = "instr.hex";

    // Program counter value held through reset
    localparam wordT RESET_VECTOR = '0;

endpackage

`default_nettype wire

// ==== rtl/fetchPkg.sv ====
// Flow-control strobes, target operands and fetch result bundles
`default_nettype none

package fetchPkg;

    ////////////////////
    // Flow control
    ////////////////////

    // Strobes from decode, sampled as plain levels every cycle
    typedef struct packed {
        logic beqz;
        logic bnez;
        logic jump;
        logic jumpReg;
    } flowCtrlT;

    ////////////////////
    // Target operands
    ////////////////////

    // The jump field is sign-extended here, the immediate arrives already extended
    typedef struct packed {
        logic [isaPkg::IMM_W-1:0] jumpValue;
        isaPkg::wordT             extendedImm;
        isaPkg::wordT             registerS1;
    } targetsT;

    ////////////////////
    // Fetch result
    ////////////////////

    typedef struct packed {
        isaPkg::wordT instruction;
        isaPkg::wordT pcPlus4;
    } fetchOutT;

endpackage

`default_nettype wire

// ==== rtl/programCounter.sv ====
// Program counter register with start-address override
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  logic         clk,
    input  logic         rstN,
    input  logic         pcSelect,
    input  isaPkg::wordT startAddress,
    input  isaPkg::wordT nextAddress,
    output isaPkg::wordT currentAddress
);

    import isaPkg::*;

    wordT pcReg;

    ////////////////////
    // Stored counter
    ////////////////////

    // One instruction per cycle, there is no stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= RESET_VECTOR;
        end else begin
            pcReg <= nextAddress;
        end
    end

    ////////////////////
    // Start override
    ////////////////////

    // A new program is fetched in the same cycle that pcSelect rises
    always_comb begin
        if (pcSelect) begin
            currentAddress = startAddress;
        end else begin
            currentAddress = pcReg;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/nextPcLogic.sv ====
// Branch condition, target adders and next program counter selection
`timescale 1ns/1ps
`default_nettype none

module nextPcLogic (
    input  isaPkg::wordT       currentAddress,
    input  logic               zFlag,
    input  fetchPkg::flowCtrlT flow,
    input  fetchPkg::targetsT  targets,
    output isaPkg::wordT       pcPlus4,
    output isaPkg::wordT       nextAddress
);

    import isaPkg::*;

    wordT seqAddress;
    wordT shiftedImm;
    wordT branchTarget;
    wordT jumpTarget;
    wordT absTarget;
    logic branchTaken;

    ////////////////////
    // Adders
    ////////////////////

    assign seqAddress = currentAddress + wordT'(BYTES_PER_WORD);

    // Branch offset counts words, so it becomes a byte offset here
    assign shiftedImm = {
        targets.extendedImm[WORD_W-WORD_OFFSET_W-1:0],
        {WORD_OFFSET_W{1'b0}}
    };

    assign branchTarget = seqAddress + shiftedImm;

    ////////////////////
    // Jump targets
    ////////////////////

    assign absTarget = {
        {(WORD_W-IMM_W){targets.jumpValue[IMM_W-1]}},
        targets.jumpValue
    };

    always_comb begin
        if (flow.jumpReg) begin
            jumpTarget = targets.registerS1;
        end else begin
            jumpTarget = absTarget;
        end
    end

    ////////////////////
    // Branch condition
    ////////////////////

    // Not-zero is simply the complement of the zero flag
    assign branchTaken = (flow.beqz && zFlag) || (flow.bnez && !zFlag);

    ////////////////////
    // Next address
    ////////////////////

    // A jump wins over a branch taken in the same cycle
    always_comb begin
        if (flow.jump) begin
            nextAddress = jumpTarget;
        end else if (branchTaken) begin
            nextAddress = branchTarget;
        end else begin
            nextAddress = seqAddress;
        end
    end

    assign pcPlus4 = seqAddress;

endmodule

`default_nettype wire

// ==== rtl/instructionMemory.sv ====
// Read-only word-addressed instruction store loaded from a hex image
`timescale 1ns/1ps
`default_nettype none

module instructionMemory (
    input  isaPkg::wordT address,
    output isaPkg::wordT instruction
);

    import isaPkg::*;

    wordT              memArray [0:IMEM_WORDS-1];
    logic [IMEM_AW-1:0] wordIndex;

    ////////////////////
    // Image load
    ////////////////////

    initial begin
        $readmemh(IMEM_FILE, memArray);
    end

    ////////////////////
    // Read port
    ////////////////////

    // Byte offset bits are dropped and upper bits ignored, so the store wraps
    assign wordIndex = address[IMEM_AW+WORD_OFFSET_W-1:WORD_OFFSET_W];

    // asynchronous read, valid in the cycle the address is presented
    assign instruction = memArray[wordIndex];

endmodule

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
// Instruction fetch top level with program counter, next-address logic and memory
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               pcSelect,
    input  isaPkg::wordT       startAddress,
    input  logic               zFlag,
    input  fetchPkg::flowCtrlT flow,
    input  fetchPkg::targetsT  targets,
    output fetchPkg::fetchOutT fetched
);

    import isaPkg::*;
    import fetchPkg::*;

    wordT currentAddress;
    wordT nextAddress;
    wordT pcPlus4;
    wordT instruction;

    ////////////////////
    // Input side
    ////////////////////

    programCounter pcInst (
        .clk            (clk),
        .rstN           (rstN),
        .pcSelect       (pcSelect),
        .startAddress   (startAddress),
        .nextAddress    (nextAddress),
        .currentAddress (currentAddress)
    );

    ////////////////////
    // Next address
    ////////////////////

    nextPcLogic nextPcInst (
        .currentAddress (currentAddress),
        .zFlag          (zFlag),
        .flow           (flow),
        .targets        (targets),
        .pcPlus4        (pcPlus4),
        .nextAddress    (nextAddress)
    );

    ////////////////////
    // Output side
    ////////////////////

    instructionMemory imemInst (
        .address     (currentAddress),
        .instruction (instruction)
    );

    // Whole path is combinational, the bundle belongs to the current address
    assign fetched = fetchOutT'{instruction: instruction, pcPlus4: pcPlus4};

endmodule

`default_nettype wire

// ==== testbench/fetchUnitChk.sv ====
// Bound assertions on the fetch unit program counter and fetch outputs
`timescale 1ns/1ps
`default_nettype none

module fetchUnitChk (
    input logic               clk,
    input logic               rstN,
    input logic               pcSelect,
    input isaPkg::wordT       currentAddress,
    input fetchPkg::fetchOutT fetched
);

    import isaPkg::*;
    import fetchPkg::*;

    ////////////////////
    // Reset state
    ////////////////////

    // The start override is kept low in reset so the stored counter shows through
    resetVectorHeld: assert property (
        @(posedge clk) (!rstN && !pcSelect) |-> (currentAddress == RESET_VECTOR)
    ) else $error("Program counter left the reset vector while in reset");

    ////////////////////
    // Fetch outputs
    ////////////////////

    sequentialAddress: assert property (
        @(posedge clk) fetched.pcPlus4 == currentAddress + 32'd4
    ) else $error("Sequential address is not the current address plus four");

    instructionKnown: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown(fetched.instruction)
    ) else $error("Fetched instruction holds unknown bits");

endmodule

bind fetchUnit fetchUnitChk chkInst (
    .clk            (clk),
    .rstN           (rstN),
    .pcSelect       (pcSelect),
    .currentAddress (currentAddress),
    .fetched        (fetched)
);

`default_nettype wire

// ==== testbench/fetchUnitTb.sv ====
// Fetch unit testbench with stimulus, reference model, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module fetchUnitTb;

    import isaPkg::*;
    import fetchPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 2;
    localparam int RANDOM_CYCLES = 150;

    // Stimulus runs for about 250 cycles so this leaves ample margin
    localparam int MAX_CYCLES = 400;

    // Strobe order is beqz, bnez, jump, jumpReg
    localparam flowCtrlT FLOW_NONE = 4'b0000;
    localparam flowCtrlT FLOW_BEQZ = 4'b1000;
    localparam flowCtrlT FLOW_BNEZ = 4'b0100;
    localparam flowCtrlT FLOW_JUMP = 4'b0010;
    localparam flowCtrlT FLOW_JREG = 4'b0011;
    localparam flowCtrlT FLOW_JUMP_BEQZ = 4'b1010;

    logic     clk;
    logic     rstN;
    logic     pcSelect;
    wordT     startAddress;
    logic     zFlag;
    flowCtrlT flow;
    targetsT  targets;
    fetchOutT fetched;

    wordT   imageWords [0:IMEM_WORDS-1];
    wordT   modelPc = RESET_VECTOR;
    integer seed;
    int     cycleCount = 0;

    fetchUnit dut (
        .clk          (clk),
        .rstN         (rstN),
        .pcSelect     (pcSelect),
        .startAddress (startAddress),
        .zFlag        (zFlag),
        .flow         (flow),
        .targets      (targets),
        .fetched      (fetched)
    );

    // The simulation runs in the folder that holds the image
    initial begin
        $readmemh(IMEM_FILE, imageWords);
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic wordT expectedNext(input wordT addr, input logic zf,
                                          input flowCtrlT fl, input targetsT tg);
        wordT seq;
        seq = addr + 32'd4;
        if (fl.jump) begin
            if (fl.jumpReg) begin
                return tg.registerS1;
            end
            return 32'(signed'(tg.jumpValue));
        end
        if ((fl.beqz && zf) || (fl.bnez && !zf)) begin
            return seq + (tg.extendedImm << 2);
        end
        return seq;
    endfunction

    function automatic targetsT makeTargets(input logic [IMM_W-1:0] jv, input wordT imm,
                                            input wordT rs1);
        return '{jumpValue: jv, extendedImm: imm, registerS1: rs1};
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkFetch(input fetchOutT actual, input fetchOutT expected);
        if (actual.instruction !== expected.instruction) begin
            stopOnError($sformatf("Fail fetched.instruction: got %h, expected %h",
                                  actual.instruction, expected.instruction));
        end else if (actual.pcPlus4 !== expected.pcPlus4) begin
            stopOnError($sformatf("Fail fetched.pcPlus4: got %h, expected %h",
                                  actual.pcPlus4, expected.pcPlus4));
        end
    endtask

    task automatic checkAddress(input wordT actual, input wordT expected);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail currentAddress: got %h, expected %h",
                                  actual, expected));
        end
    endtask

    // Samples one nanosecond before the edge and then advances the model
    always begin : compareProc
        wordT     effAddr;
        fetchOutT expected;
        @(posedge clk);
        #(CLK_PERIOD - 1);
        effAddr = pcSelect ? startAddress : modelPc;
        if (rstN) begin
            expected.instruction = imageWords[effAddr[IMEM_AW+1:2]];
            expected.pcPlus4 = effAddr + 32'd4;
            checkFetch(fetched, expected);
            checkAddress(dut.currentAddress, effAddr);
        end
        if (!rstN) begin
            modelPc = RESET_VECTOR;
        end else begin
            modelPc = expectedNext(effAddr, zFlag, flow, targets);
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == MAX_CYCLES) begin
            stopOnError("The run reached its cycle limit without finishing");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic driveCycle(input logic sel, input wordT start, input logic zf,
                              input flowCtrlT fl, input targetsT tg);
        @(posedge clk);
        pcSelect <= sel;
        startAddress <= start;
        zFlag <= zf;
        flow <= fl;
        targets <= tg;
    endtask

    task automatic runIdle(input int count);
        repeat (count) begin
            driveCycle(1'b0, '0, 1'b0, FLOW_NONE, '0);
        end
    endtask

    initial begin : stimulus
        logic [31:0] ctrlRnd;
        logic [31:0] jumpRnd;
        logic [31:0] immRnd;
        logic [31:0] regRnd;
        seed = 54;
        rstN <= 1'b0;
        pcSelect <= 1'b0;
        startAddress <= '0;
        zFlag <= 1'b0;
        flow <= FLOW_NONE;
        targets <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        // Straight-line fetch runs past the 64-word wrap
        runIdle(70);

        driveCycle(1'b1, 32'h0000_1A0C, 1'b0, FLOW_NONE, '0);
        driveCycle(1'b1, 32'h0000_1A0C, 1'b0, FLOW_NONE, '0);
        runIdle(3);

        // Taken and untaken branches with both immediate signs
        driveCycle(1'b0, '0, 1'b1, FLOW_BEQZ, makeTargets('0, 32'd5, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b0, FLOW_BEQZ, makeTargets('0, 32'd5, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b0, FLOW_BNEZ, makeTargets('0, 32'hFFFF_FFFD, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b1, FLOW_BNEZ, makeTargets('0, 32'hFFFF_FFFD, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b1, FLOW_BEQZ, makeTargets('0, 32'hFFFF_FFF0, '0));
        runIdle(1);

        driveCycle(1'b0, '0, 1'b0, FLOW_JUMP, makeTargets(26'h000_0240, '0, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b0, FLOW_JUMP, makeTargets(26'h3FF_FF00, '0, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b1, FLOW_JUMP_BEQZ, makeTargets(26'h000_0080, 32'd16, '0));
        runIdle(1);
        driveCycle(1'b0, '0, 1'b0, FLOW_JREG,
                   makeTargets(26'h000_0300, '0, 32'h0000_0044));
        runIdle(1);

        ////////////////////
        // Random flow
        ////////////////////

        repeat (RANDOM_CYCLES) begin
            ctrlRnd = $random(seed);
            jumpRnd = $random(seed);
            immRnd = $random(seed);
            regRnd = $random(seed);
            driveCycle(1'b0, '0, ctrlRnd[4], ctrlRnd[3:0],
                       makeTargets({jumpRnd[IMM_W-1:2], 2'b00}, immRnd,
                                   {regRnd[31:2], 2'b00}));
        end
        runIdle(1);

        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/instr.hex ====
// One 32-bit instruction word per line in hex, word index 0 to 63 in order
AA0055FF
AA0155FE
AA0255FD
AA0355FC
AA0455FB
AA0555FA
AA0655F9
AA0755F8
AA0855F7
AA0955F6
AA0A55F5
AA0B55F4
AA0C55F3
AA0D55F2
AA0E55F1
AA0F55F0
AA1055EF
AA1155EE
AA1255ED
AA1355EC
AA1455EB
AA1555EA
AA1655E9
AA1755E8
AA1855E7
AA1955E6
AA1A55E5
AA1B55E4
AA1C55E3
AA1D55E2
AA1E55E1
AA1F55E0
AA2055DF
AA2155DE
AA2255DD
AA2355DC
AA2455DB
AA2555DA
AA2655D9
AA2755D8
AA2855D7
AA2955D6
AA2A55D5
AA2B55D4
AA2C55D3
AA2D55D2
AA2E55D1
AA2F55D0
AA3055CF
AA3155CE
AA3255CD
AA3355CC
AA3455CB
AA3555CA
AA3655C9
AA3755C8
AA3855C7
AA3955C6
AA3A55C5
AA3B55C4
AA3C55C3
AA3D55C2
AA3E55C1
AA3F55C0

// ==== project.f ====
rtl/isaPkg.sv
rtl/fetchPkg.sv
rtl/programCounter.sv
rtl/nextPcLogic.sv
rtl/instructionMemory.sv
rtl/fetchUnit.sv
testbench/fetchUnitChk.sv
testbench/fetchUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch unit testbench and runs it from the folder that holds instr.hex
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetchUnitTb -f project.f -o fetchUnitSim &&
(cd testbench && ../obj_dir/fetchUnitSim) | tee /dev/stderr | grep -q "TB PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run did not succeed"; exit 1; }
